// ==== opreq_stage.f ====
verilog/opreq_pkg.sv
verilog/opreq_decode.sv
verilog/operand_requester.sv
verilog/vrf_bank_arbiter.sv
verilog/vfu_result_port.sv
verilog/opreq_stage.sv
+incdir+sim
sim/tb_opreq_stage.sv

// ==== sim/tb_opreq_tasks.svh ====
// Included inside the testbench module; every task starts and ends on a falling clock edge
`ifndef TB_OPREQ_TASKS_SVH
`define TB_OPREQ_TASKS_SVH

////////////////////
// Checking
////////////////////

task automatic stop_run();
  $display("FAIL: see errors above");
  $fatal(1, "simulation stopped");
endtask

task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
  if (exp !== act) begin
    err_cnt++;
    $display("ERR %s: expected %0h, actual %0h", name, exp, act);
    stop_run();
  end
endtask

task automatic timeout_fail(input string what);
  $display("Timed out waiting for %s", what);
  stop_run();
endtask

function automatic logic [31:0] xorshift(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

task automatic draw(output logic [63:0] w);
  rng_q     = xorshift(rng_q);
  w[63:32]  = rng_q;
  rng_q     = xorshift(rng_q);
  w[31:0]   = rng_q;
endtask

// Expected word address and word count from the command rules
function automatic int exp_start(input opreq_pkg::opreq_cmd_t c);
  return int'(c.vs) * 8 + int'(c.vstart) / (8 >> int'(c.eew));
endfunction

function automatic int exp_words(input opreq_pkg::opreq_cmd_t c);
  int epw;
  epw = 8 >> int'(c.eew);
  return (int'(c.vl) + epw - 1) / epw;
endfunction

function automatic int count_reads(input int q);
  int n;
  n = 0;
  foreach (mon_pay[i]) begin
    if (!mon_pay[i].wen && int'(mon_pay[i].opqueue) == q) begin
      n++;
    end
  end
  return n;
endfunction

// Reads of one queue must cover start..start+n-1 in order
task automatic check_reads(input string name, input int q, input int start, input int n);
  int k;
  int a;
  k = 0;
  foreach (mon_pay[i]) begin
    if (!mon_pay[i].wen && int'(mon_pay[i].opqueue) == q) begin
      a = start + k;
      check_eq({name, " bank"}, a % 4, mon_bank[i]);
      check_eq({name, " bank address"}, a / 4, mon_pay[i].addr);
      k++;
    end
  end
  check_eq({name, " read count"}, n, k);
endtask

////////////////////
// Drive helpers
////////////////////

task automatic idle_inputs();
  global_hazard_i = '0;
  opreq_i         = '0;
  opreq_valid_i   = '0;
  queue_ready_i   = '1;
  alu_req_i       = 1'b0;
  alu_res_i       = '0;
  ldu_req_i       = 1'b0;
  ldu_res_i       = '0;
endtask

task automatic clear_monitor();
  mon_bank.delete();
  mon_pay.delete();
  mon_cyc.delete();
  final_cyc.delete();
  issued_cnt = '{default: 0};
  cmdv_cnt   = '{default: 0};
endtask

function automatic opreq_pkg::opreq_cmd_t make_cmd(input int id, input int vs, input int vstart,
                                                   input int vl, input opreq_pkg::vew_e eew,
                                                   input logic [3:0] hazard);
  opreq_pkg::opreq_cmd_t c;
  c.id     = opreq_pkg::vid_t'(id);
  c.vs     = 5'(vs);
  c.vstart = opreq_pkg::vlen_t'(vstart);
  c.vl     = opreq_pkg::vlen_t'(vl);
  c.eew    = eew;
  c.hazard = hazard;
  return c;
endfunction

// Holds valid until the requester is ready and returns what the queue saw
task automatic send_cmd(input int q, input opreq_pkg::opreq_cmd_t cmd, output logic cv,
                        output opreq_pkg::opq_cmd_t oc);
  int cnt;
  cnt = 0;
  @(negedge clk_i);
  opreq_i[q]       = cmd;
  opreq_valid_i[q] = 1'b1;
  @(posedge clk_i);
  while (!opreq_ready_o[q]) begin
    cnt++;
    if (cnt > 50) begin
      timeout_fail("requester ready");
    end
    @(posedge clk_i);
  end
  cv = opq_cmd_valid_o[q];
  oc = opq_cmd_o[q];
  @(negedge clk_i);
  opreq_valid_i[q] = 1'b0;
endtask

task automatic alu_write(input opreq_pkg::vfu_result_t res, input string name);
  @(negedge clk_i);
  alu_req_i = 1'b1;
  alu_res_i = res;
  @(posedge clk_i);
  check_eq({name, " alu_gnt"}, 1, alu_gnt_o);
  check_eq({name, " same-cycle bank request"}, 1, vrf_req_o[res.addr[1:0]]);
  @(negedge clk_i);
  alu_req_i = 1'b0;
endtask

task automatic wait_issued(input int q, input int n, input string what);
  int cnt;
  cnt = 0;
  while (issued_cnt[q] < n) begin
    @(negedge clk_i);
    cnt++;
    if (cnt > 100) begin
      timeout_fail(what);
    end
  end
endtask

task automatic wait_final(input string what);
  int cnt;
  cnt = 0;
  while (final_cyc.size() == 0) begin
    @(negedge clk_i);
    cnt++;
    if (cnt > 20) begin
      timeout_fail(what);
    end
  end
endtask

////////////////////
// Directed tests
////////////////////

task automatic test_reset_state();
  @(posedge clk_i);
  check_eq("reset cmd_valid", 0, opq_cmd_valid_o);
  check_eq("reset operand_issued", 0, operand_issued_o);
  check_eq("reset vrf_req", 0, vrf_req_o);
  check_eq("reset ldu_final_gnt", 0, ldu_final_gnt_o);
  check_eq("reset alu_gnt", 0, alu_gnt_o);
  @(negedge clk_i);
endtask

task automatic test_read_walk();
  opreq_pkg::opreq_cmd_t cmd;
  opreq_pkg::opq_cmd_t   oc;
  logic                  cv;
  cmd = make_cmd(0, 2, 0, 16, opreq_pkg::EW32, 4'b0000);
  clear_monitor();
  send_cmd(0, cmd, cv, oc);
  check_eq("read walk cmd_valid", 1, cv);
  check_eq("read walk cmd vl", 16, oc.vl);
  check_eq("read walk cmd eew", opreq_pkg::EW32, oc.eew);
  check_eq("read walk busy", 0, opreq_ready_o[0]);
  wait_issued(0, exp_words(cmd), "read walk operands");
  repeat (2) @(negedge clk_i);
  check_eq("read walk issued", 8, issued_cnt[0]);
  check_eq("read walk queue commands", 1, cmdv_cnt[0]);
  check_eq("read walk ready", 1, opreq_ready_o[0]);
  check_reads("read walk", 0, exp_start(cmd), exp_words(cmd));
endtask

task automatic test_empty_cmd();
  opreq_pkg::opreq_cmd_t cmd;
  opreq_pkg::opq_cmd_t   oc;
  logic                  cv;
  cmd = make_cmd(1, 1, 0, 0, opreq_pkg::EW64, 4'b0000);
  clear_monitor();
  send_cmd(0, cmd, cv, oc);
  check_eq("empty cmd_valid", 0, cv);
  repeat (10) @(negedge clk_i);
  check_eq("empty bank accesses", 0, mon_pay.size());
  check_eq("empty queue commands", 0, cmdv_cnt[0]);
  check_eq("empty ready", 1, opreq_ready_o[0]);
endtask

task automatic test_alu_write();
  opreq_pkg::vfu_result_t res;
  logic [63:0]            w;
  draw(w);
  res       = '0;
  res.id    = 2'd0;
  res.addr  = 8'h35;
  res.wdata = w;
  res.be    = w[7:0];
  clear_monitor();
  alu_write(res, "alu write");
  check_eq("alu write count", 1, mon_pay.size());
  check_eq("alu write bank", res.addr % 4, mon_bank[0]);
  check_eq("alu write bank address", res.addr / 4, mon_pay[0].addr);
  check_eq("alu write wen", 1, mon_pay[0].wen);
  check_eq("alu write data", res.wdata, mon_pay[0].wdata);
  check_eq("alu write be", res.be, mon_pay[0].be);
endtask

// The skid entry and the ALU ask for bank 2 in the same cycle and the ALU goes first
task automatic test_load_priority();
  opreq_pkg::vfu_result_t alu;
  opreq_pkg::vfu_result_t ldu;
  logic [63:0]            wa;
  logic [63:0]            wl;
  draw(wa);
  draw(wl);
  alu = '{id: 2'd1, addr: 8'h12, wdata: wa, be: 8'hff};
  ldu = '{id: 2'd3, addr: 8'h46, wdata: wl, be: 8'h0f};
  clear_monitor();
  @(negedge clk_i);
  ldu_req_i = 1'b1;
  ldu_res_i = ldu;
  @(posedge clk_i);
  check_eq("load ldu_gnt", 1, ldu_gnt_o);
  @(negedge clk_i);
  ldu_req_i = 1'b0;
  alu_req_i = 1'b1;
  alu_res_i = alu;
  @(posedge clk_i);
  check_eq("load alu_gnt", 1, alu_gnt_o);
  @(negedge clk_i);
  alu_req_i = 1'b0;
  wait_final("load final grant");
  repeat (2) @(negedge clk_i);
  check_eq("load write count", 2, mon_pay.size());
  check_eq("load first is alu", wa, mon_pay[0].wdata);
  check_eq("load second is ldu", wl, mon_pay[1].wdata);
  check_eq("load bank", 2, mon_bank[1]);
  check_eq("load bank address", ldu.addr / 4, mon_pay[1].addr);
  check_eq("load be", ldu.be, mon_pay[1].be);
  check_eq("load after alu", 1, mon_cyc[1] > mon_cyc[0]);
  check_eq("load final pulses", 1, final_cyc.size());
  check_eq("load final cycle", mon_cyc[1] + 1, final_cyc[0]);
endtask

task automatic test_hazard_stall();
  opreq_pkg::opreq_cmd_t  cmd;
  opreq_pkg::opq_cmd_t    oc;
  opreq_pkg::vfu_result_t res;
  logic                   cv;
  logic [63:0]            w;
  cmd = make_cmd(1, 3, 0, 4, opreq_pkg::EW64, 4'b0100);
  global_hazard_i       = '0;
  global_hazard_i[1][2] = 1'b1;
  clear_monitor();
  send_cmd(1, cmd, cv, oc);
  check_eq("hazard cmd_valid", 1, cv);
  repeat (6) @(negedge clk_i);
  check_eq("hazard stalled reads", 0, count_reads(1));
  res      = '0;
  res.id   = 2'd2;
  res.addr = 8'h80;
  res.be   = 8'hff;
  // One write of id 2 opens a single cycle for the read
  for (int i = 1; i <= 2; i++) begin
    draw(w);
    res.wdata = w;
    alu_write(res, "hazard release");
    repeat (4) @(negedge clk_i);
    check_eq("hazard reads per write", i, count_reads(1));
  end
  global_hazard_i = '0;
  wait_issued(1, exp_words(cmd), "hazard walk");
  check_reads("hazard walk", 1, exp_start(cmd), exp_words(cmd));
endtask

task automatic test_backpressure();
  opreq_pkg::opreq_cmd_t cmd;
  opreq_pkg::opq_cmd_t   oc;
  logic                  cv;
  int                    held;
  cmd = make_cmd(2, 5, 8, 64, opreq_pkg::EW8, 4'b0000);
  queue_ready_i[0] = 1'b0;
  clear_monitor();
  send_cmd(0, cmd, cv, oc);
  repeat (8) @(negedge clk_i);
  check_eq("backpressure held", 0, count_reads(0));
  queue_ready_i[0] = 1'b1;
  repeat (3) @(negedge clk_i);
  queue_ready_i[0] = 1'b0;
  held = count_reads(0);
  repeat (4) @(negedge clk_i);
  check_eq("backpressure held again", held, count_reads(0));
  queue_ready_i[0] = 1'b1;
  wait_issued(0, exp_words(cmd), "backpressure walk");
  check_reads("backpressure walk", 0, exp_start(cmd), exp_words(cmd));
endtask

`endif

// ==== sim/tb_opreq_stage.sv ====
// Register file is modelled as always ready and stores nothing; only granted accesses are logged
`timescale 1ns/1ps

module tb_opreq_stage;

  logic                                                 clk_i;
  logic                                                 rst_ni;
  opreq_pkg::hazard_tbl_t                               global_hazard_i;
  opreq_pkg::opreq_cmd_t [opreq_pkg::NR_OPQUEUES-1:0]   opreq_i;
  logic [opreq_pkg::NR_OPQUEUES-1:0]                    opreq_valid_i;
  logic [opreq_pkg::NR_OPQUEUES-1:0]                    opreq_ready_o;
  logic [opreq_pkg::NR_OPQUEUES-1:0]                    queue_ready_i;
  logic [opreq_pkg::NR_OPQUEUES-1:0]                    operand_issued_o;
  opreq_pkg::opq_cmd_t [opreq_pkg::NR_OPQUEUES-1:0]     opq_cmd_o;
  logic [opreq_pkg::NR_OPQUEUES-1:0]                    opq_cmd_valid_o;
  logic                                                 alu_req_i;
  opreq_pkg::vfu_result_t                               alu_res_i;
  logic                                                 alu_gnt_o;
  logic                                                 ldu_req_i;
  opreq_pkg::vfu_result_t                               ldu_res_i;
  logic                                                 ldu_gnt_o;
  logic                                                 ldu_final_gnt_o;
  logic [opreq_pkg::NR_BANKS-1:0]                       vrf_req_o;
  opreq_pkg::vrf_req_t [opreq_pkg::NR_BANKS-1:0]        vrf_payload_o;

  // Bank monitor log, one entry per granted access
  int                  mon_bank[$];
  opreq_pkg::vrf_req_t mon_pay[$];
  int                  mon_cyc[$];
  int                  final_cyc[$];
  int                  issued_cnt[opreq_pkg::NR_OPQUEUES];
  int                  cmdv_cnt[opreq_pkg::NR_OPQUEUES];
  int                  cyc;
  int                  err_cnt;
  logic [31:0]         rng_q;

  opreq_stage u_dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .global_hazard_i (global_hazard_i),
    .opreq_i         (opreq_i),
    .opreq_valid_i   (opreq_valid_i),
    .opreq_ready_o   (opreq_ready_o),
    .queue_ready_i   (queue_ready_i),
    .operand_issued_o(operand_issued_o),
    .opq_cmd_o       (opq_cmd_o),
    .opq_cmd_valid_o (opq_cmd_valid_o),
    .alu_req_i       (alu_req_i),
    .alu_res_i       (alu_res_i),
    .alu_gnt_o       (alu_gnt_o),
    .ldu_req_i       (ldu_req_i),
    .ldu_res_i       (ldu_res_i),
    .ldu_gnt_o       (ldu_gnt_o),
    .ldu_final_gnt_o (ldu_final_gnt_o),
    .vrf_req_o       (vrf_req_o),
    .vrf_payload_o   (vrf_payload_o)
  );

  `include "tb_opreq_tasks.svh"

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////
  // Bank monitor
  ////////////////////

  // Values seen just before the edge, when the register file takes each access
  always @(posedge clk_i) begin
    if (rst_ni) begin
      for (int b = 0; b < opreq_pkg::NR_BANKS; b++) begin
        if (vrf_req_o[b]) begin
          mon_bank.push_back(b);
          mon_pay.push_back(vrf_payload_o[b]);
          mon_cyc.push_back(cyc);
        end
      end
      for (int q = 0; q < opreq_pkg::NR_OPQUEUES; q++) begin
        issued_cnt[q] += int'(operand_issued_o[q]);
        cmdv_cnt[q]   += int'(opq_cmd_valid_o[q]);
      end
      if (ldu_final_gnt_o) begin
        final_cyc.push_back(cyc);
      end
      cyc++;
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    cyc     = 0;
    err_cnt = 0;
    rng_q   = 32'h4288_0202;
    rst_ni  = 1'b0;
    idle_inputs();
    clear_monitor();
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    test_reset_state();
    test_read_walk();
    test_empty_cmd();
    test_alu_write();
    test_load_priority();
    test_hazard_stall();
    test_backpressure();

    if (err_cnt == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      stop_run();
    end
  end

endmodule

// ==== verilog/opreq_stage.sv ====
// Single-lane operand requester stage; the register file must accept every bank request
`timescale 1ns/1ps

module opreq_stage (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  opreq_pkg::hazard_tbl_t                          global_hazard_i,
  input  opreq_pkg::opreq_cmd_t [opreq_pkg::NR_OPQUEUES-1:0] opreq_i,
  input  logic [opreq_pkg::NR_OPQUEUES-1:0]               opreq_valid_i,
  output logic [opreq_pkg::NR_OPQUEUES-1:0]               opreq_ready_o,
  input  logic [opreq_pkg::NR_OPQUEUES-1:0]               queue_ready_i,
  output logic [opreq_pkg::NR_OPQUEUES-1:0]               operand_issued_o,
  output opreq_pkg::opq_cmd_t [opreq_pkg::NR_OPQUEUES-1:0] opq_cmd_o,
  output logic [opreq_pkg::NR_OPQUEUES-1:0]               opq_cmd_valid_o,
  input  logic                                            alu_req_i,
  input  opreq_pkg::vfu_result_t                          alu_res_i,
  output logic                                            alu_gnt_o,
  input  logic                                            ldu_req_i,
  input  opreq_pkg::vfu_result_t                          ldu_res_i,
  output logic                                            ldu_gnt_o,
  output logic                                            ldu_final_gnt_o,
  output logic [opreq_pkg::NR_BANKS-1:0]                  vrf_req_o,
  output opreq_pkg::vrf_req_t [opreq_pkg::NR_BANKS-1:0]   vrf_payload_o
);

  // Per master: bank requests, bank grants and payload
  logic [opreq_pkg::NR_MASTERS-1:0][opreq_pkg::NR_BANKS-1:0] mst_req;
  logic [opreq_pkg::NR_MASTERS-1:0][opreq_pkg::NR_BANKS-1:0] mst_gnt;
  opreq_pkg::vrf_req_t [opreq_pkg::NR_MASTERS-1:0]           mst_payload;
  // Per bank: the same requests and grants, transposed
  logic [opreq_pkg::NR_BANKS-1:0][opreq_pkg::NR_MASTERS-1:0] bank_req;
  logic [opreq_pkg::NR_BANKS-1:0][opreq_pkg::NR_MASTERS-1:0] bank_gnt;
  logic [opreq_pkg::NR_VINSN-1:0]                            written;

  ////////////////////
  // Read queues
  ////////////////////

  for (genvar q = 0; q < opreq_pkg::NR_OPQUEUES; q++) begin : gen_queue
    localparam int unsigned MST = (q == 0) ? opreq_pkg::MST_Q0 : opreq_pkg::MST_Q1;

    opreq_pkg::vaddr_t   start_addr;
    opreq_pkg::vlen_t    len;
    opreq_pkg::opq_cmd_t dec_cmd;
    logic                empty;

    opreq_decode u_decode (
      .cmd_i       (opreq_i[q]),
      .start_addr_o(start_addr),
      .len_o       (len),
      .opq_cmd_o   (dec_cmd),
      .empty_o     (empty)
    );

    operand_requester #(
      .QUEUE(opreq_pkg::opqueue_e'(q))
    ) u_requester (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .req_valid_i    (opreq_valid_i[q]),
      .req_ready_o    (opreq_ready_o[q]),
      .cmd_i          (opreq_i[q]),
      .start_addr_i   (start_addr),
      .len_i          (len),
      .opq_cmd_i      (dec_cmd),
      .empty_i        (empty),
      .global_hazard_i(global_hazard_i),
      .written_i      (written),
      .queue_ready_i  (queue_ready_i[q]),
      .cmd_o          (opq_cmd_o[q]),
      .cmd_valid_o    (opq_cmd_valid_o[q]),
      .bank_req_o     (mst_req[MST]),
      .payload_o      (mst_payload[MST]),
      .gnt_i          (mst_gnt[MST]),
      .issued_o       (operand_issued_o[q])
    );
  end

  ////////////////////
  // Write ports
  ////////////////////

  vfu_result_port u_result_port (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .alu_req_i      (alu_req_i),
    .alu_res_i      (alu_res_i),
    .alu_gnt_o      (alu_gnt_o),
    .ldu_req_i      (ldu_req_i),
    .ldu_res_i      (ldu_res_i),
    .ldu_gnt_o      (ldu_gnt_o),
    .ldu_final_gnt_o(ldu_final_gnt_o),
    .alu_bank_req_o (mst_req[opreq_pkg::MST_ALU]),
    .ldu_bank_req_o (mst_req[opreq_pkg::MST_LDU]),
    .alu_payload_o  (mst_payload[opreq_pkg::MST_ALU]),
    .ldu_payload_o  (mst_payload[opreq_pkg::MST_LDU]),
    .alu_bank_gnt_i (mst_gnt[opreq_pkg::MST_ALU]),
    .ldu_bank_gnt_i (mst_gnt[opreq_pkg::MST_LDU]),
    .written_o      (written)
  );

  ////////////////////
  // Bank arbiters
  ////////////////////

  for (genvar b = 0; b < opreq_pkg::NR_BANKS; b++) begin : gen_bank
    for (genvar m = 0; m < opreq_pkg::NR_MASTERS; m++) begin : gen_xpose
      assign bank_req[b][m] = mst_req[m][b];
      assign mst_gnt[m][b]  = bank_gnt[b][m];
    end

    vrf_bank_arbiter u_arbiter (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .req_i        (bank_req[b]),
      .payload_i    (mst_payload),
      .gnt_o        (bank_gnt[b]),
      .vrf_req_o    (vrf_req_o[b]),
      .vrf_payload_o(vrf_payload_o[b])
    );
  end

endmodule

// ==== verilog/vfu_result_port.sv ====
// ALU writes pass straight through; load writes wait in a two-entry skid with a late final grant
`timescale 1ns/1ps

module vfu_result_port (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               alu_req_i,
  input  opreq_pkg::vfu_result_t             alu_res_i,
  output logic                               alu_gnt_o,
  input  logic                               ldu_req_i,
  input  opreq_pkg::vfu_result_t             ldu_res_i,
  output logic                               ldu_gnt_o,
  output logic                               ldu_final_gnt_o,
  output logic [opreq_pkg::NR_BANKS-1:0]     alu_bank_req_o,
  output logic [opreq_pkg::NR_BANKS-1:0]     ldu_bank_req_o,
  output opreq_pkg::vrf_req_t                alu_payload_o,
  output opreq_pkg::vrf_req_t                ldu_payload_o,
  input  logic [opreq_pkg::NR_BANKS-1:0]     alu_bank_gnt_i,
  input  logic [opreq_pkg::NR_BANKS-1:0]     ldu_bank_gnt_i,
  output logic [opreq_pkg::NR_VINSN-1:0]     written_o
);

  opreq_pkg::vfu_result_t         skid_q [2];
  opreq_pkg::vfu_result_t         ldu_head;
  logic                           wr_ptr_q, rd_ptr_q;
  logic [1:0]                     cnt_q;
  logic                           ldu_push, ldu_pop;
  logic [opreq_pkg::NR_VINSN-1:0] written_d;

  function automatic opreq_pkg::vrf_req_t to_write(opreq_pkg::vfu_result_t res);
    opreq_pkg::vrf_req_t req;
    req       = '0;
    req.addr  = res.addr[opreq_pkg::VADDR_W-1:opreq_pkg::BANK_IDX_W];
    req.wen   = 1'b1;
    req.wdata = res.wdata;
    req.be    = res.be;
    return req;
  endfunction

  ////////////////////
  // Write sources
  ////////////////////

  assign ldu_head      = skid_q[rd_ptr_q];
  assign alu_payload_o = to_write(alu_res_i);
  assign ldu_payload_o = to_write(ldu_head);
  assign alu_gnt_o     = |alu_bank_gnt_i;
  assign ldu_gnt_o     = (cnt_q != 2'd2);
  assign ldu_push      = ldu_req_i && ldu_gnt_o;
  assign ldu_pop       = |ldu_bank_gnt_i;

  always_comb begin
    alu_bank_req_o = '0;
    ldu_bank_req_o = '0;
    alu_bank_req_o[alu_res_i.addr[opreq_pkg::BANK_IDX_W-1:0]] = alu_req_i;
    ldu_bank_req_o[ldu_head.addr[opreq_pkg::BANK_IDX_W-1:0]]  = (cnt_q != 2'd0);
  end

  // Ids that reached the register file this cycle
  always_comb begin
    written_d = '0;
    written_d[alu_res_i.id] = written_d[alu_res_i.id] | alu_gnt_o;
    written_d[ldu_head.id]  = written_d[ldu_head.id] | ldu_pop;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q        <= 1'b0;
      rd_ptr_q        <= 1'b0;
      cnt_q           <= 2'd0;
      ldu_final_gnt_o <= 1'b0;
      written_o       <= '0;
    end else begin
      wr_ptr_q        <= wr_ptr_q ^ ldu_push;
      rd_ptr_q        <= rd_ptr_q ^ ldu_pop;
      cnt_q           <= cnt_q + 2'(ldu_push) - 2'(ldu_pop);
      ldu_final_gnt_o <= ldu_pop;
      written_o       <= written_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ldu_push) begin
      skid_q[wr_ptr_q] <= ldu_res_i;
    end
  end

  // A final grant needs a granted load that was held in the skid
  a_final_after_gnt : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      ldu_final_gnt_o |-> $past(ldu_pop && (cnt_q != 2'd0))
  );

endmodule

// ==== verilog/vrf_bank_arbiter.sv ====
// Grant is same-cycle and the bank never back-pressures; any high request blocks the low class
`timescale 1ns/1ps

module vrf_bank_arbiter (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic [opreq_pkg::NR_MASTERS-1:0]         req_i,
  input  opreq_pkg::vrf_req_t [opreq_pkg::NR_MASTERS-1:0] payload_i,
  output logic [opreq_pkg::NR_MASTERS-1:0]         gnt_o,
  output logic                                     vrf_req_o,
  output opreq_pkg::vrf_req_t                      vrf_payload_o
);

  logic [opreq_pkg::NR_CLASSES-1:0][opreq_pkg::CLASS_IDX_W-1:0] ptr_d, ptr_q;
  logic [opreq_pkg::NR_CLASSES-1:0][opreq_pkg::CLASS_IDX_W-1:0] cls_win;
  logic [opreq_pkg::NR_CLASSES-1:0]                             cls_any;
  logic [opreq_pkg::CLASS_IDX_W-1:0]                            cand;
  logic                                                         sel_cls;
  logic [opreq_pkg::MST_IDX_W-1:0]                              gnt_idx;

  ////////////////////
  // Per-class round robin
  ////////////////////

  // Class 0 holds queue 0 and the ALU, class 1 queue 1 and the load unit
  always_comb begin
    cand = '0;
    for (int c = 0; c < opreq_pkg::NR_CLASSES; c++) begin
      cls_any[c] = 1'b0;
      cls_win[c] = ptr_q[c];
      // Scan from farthest to nearest so the one closest to the pointer wins
      for (int k = opreq_pkg::CLASS_SZ - 1; k >= 0; k--) begin
        cand = opreq_pkg::CLASS_IDX_W'(int'(ptr_q[c]) + k);
        if (req_i[c * opreq_pkg::CLASS_SZ + int'(cand)]) begin
          cls_any[c] = 1'b1;
          cls_win[c] = cand;
        end
      end
    end
  end

  ////////////////////
  // Class priority
  ////////////////////

  always_comb begin
    gnt_o   = '0;
    ptr_d   = ptr_q;
    sel_cls = !cls_any[0];
    gnt_idx = opreq_pkg::MST_IDX_W'(int'(sel_cls) * opreq_pkg::CLASS_SZ +
                                    int'(cls_win[sel_cls]));
    if (cls_any[sel_cls]) begin
      gnt_o[gnt_idx] = 1'b1;
      // Next time start past the winner
      ptr_d[sel_cls] = cls_win[sel_cls] + 1'b1;
    end
  end

  // Bank takes every request
  assign vrf_req_o     = |req_i;
  assign vrf_payload_o = payload_i[gnt_idx];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else begin
      ptr_q <= ptr_d;
    end
  end

  // Any request is served, by one grant to a requesting master
  a_single_gnt : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0) && ((|gnt_o) == (|req_i))
  );

endmodule

// ==== verilog/operand_requester.sv ====
// One queue walks one register at a time; hazards release it only in the cycle after a write
`timescale 1ns/1ps

module operand_requester #(
  parameter opreq_pkg::opqueue_e QUEUE = opreq_pkg::OPQ_A
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 req_valid_i,
  output logic                                 req_ready_o,
  input  opreq_pkg::opreq_cmd_t                cmd_i,
  input  opreq_pkg::vaddr_t                    start_addr_i,
  input  opreq_pkg::vlen_t                     len_i,
  input  opreq_pkg::opq_cmd_t                  opq_cmd_i,
  input  logic                                 empty_i,
  input  opreq_pkg::hazard_tbl_t               global_hazard_i,
  input  logic [opreq_pkg::NR_VINSN-1:0]       written_i,
  input  logic                                 queue_ready_i,
  output opreq_pkg::opq_cmd_t                  cmd_o,
  output logic                                 cmd_valid_o,
  output logic [opreq_pkg::NR_BANKS-1:0]       bank_req_o,
  output opreq_pkg::vrf_req_t                  payload_o,
  input  logic [opreq_pkg::NR_BANKS-1:0]       gnt_i,
  output logic                                 issued_o
);

  typedef enum logic {IDLE, REQUESTING} state_e;

  state_e                         state_d, state_q;
  opreq_pkg::vid_t                id_d, id_q;
  opreq_pkg::vaddr_t              addr_d, addr_q;
  opreq_pkg::vlen_t               len_d, len_q;
  opreq_pkg::vew_e                eew_d, eew_q;
  logic [opreq_pkg::NR_VINSN-1:0] hazard_d, hazard_q;
  opreq_pkg::vlen_t               epw;
  logic                           stall;

  // Every hazard source must have written in the previous cycle
  assign stall    = |(hazard_q & ~written_i);
  assign epw      = opreq_pkg::elems_per_word(eew_q);
  assign issued_o = |gnt_i;
  assign cmd_o    = opq_cmd_i;

  always_comb begin
    payload_o         = '0;
    payload_o.addr    = addr_q[opreq_pkg::VADDR_W-1:opreq_pkg::BANK_IDX_W];
    payload_o.opqueue = QUEUE;
  end

  ////////////////////
  // Walk
  ////////////////////

  always_comb begin
    state_d     = state_q;
    id_d        = id_q;
    addr_d      = addr_q;
    len_d       = len_q;
    eew_d       = eew_q;
    hazard_d    = hazard_q;
    bank_req_o  = '0;
    cmd_valid_o = 1'b0;

    if (state_q == REQUESTING) begin
      if (queue_ready_i && !stall) begin
        bank_req_o[addr_q[opreq_pkg::BANK_IDX_W-1:0]] = 1'b1;
      end
      if (|gnt_i) begin
        addr_d = addr_q + 1'b1;
        len_d  = (len_q > epw) ? len_q - epw : '0;
        if (len_d == '0) begin
          state_d = IDLE;
        end
      end
    end

    // Idle, or retiring the last word this cycle
    req_ready_o = (state_d == IDLE);

    if (req_valid_i && req_ready_o && !empty_i) begin
      cmd_valid_o = 1'b1;
      state_d     = REQUESTING;
      id_d        = cmd_i.id;
      addr_d      = start_addr_i;
      len_d       = len_i;
      eew_d       = cmd_i.eew;
      hazard_d    = cmd_i.hazard;
    end

    // Drop hazards that the sequencer has already cleared
    hazard_d = hazard_d & global_hazard_i[id_d];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      hazard_q <= '0;
    end else begin
      state_q  <= state_d;
      hazard_q <= hazard_d;
    end
  end

  always_ff @(posedge clk_i) begin
    id_q   <= id_d;
    addr_q <= addr_d;
    len_q  <= len_d;
    eew_q  <= eew_d;
  end

  // Bank arbiters only grant what this queue asked for
  a_gnt_follows_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni) (gnt_i & ~bank_req_o) == '0
  );

endmodule

// ==== verilog/opreq_decode.sv ====
// Pure combinational decode; vs must name a whole register and vstart is rounded down to a word
`timescale 1ns/1ps

module opreq_decode (
  input  opreq_pkg::opreq_cmd_t cmd_i,
  output opreq_pkg::vaddr_t     start_addr_o,
  output opreq_pkg::vlen_t      len_o,
  output opreq_pkg::opq_cmd_t   opq_cmd_o,
  output logic                  empty_o
);

  opreq_pkg::vaddr_t reg_base;
  opreq_pkg::vaddr_t word_off;
  int unsigned       shift;

  ////////////////////
  // Start address
  ////////////////////

  // Base word of the register in this lane
  assign reg_base = opreq_pkg::vaddr_t'(cmd_i.vs) * opreq_pkg::vaddr_t'(opreq_pkg::VREG_WORDS);

  // vstart in words, i.e. divided by elements per word
  assign shift    = int'(opreq_pkg::EW64) - int'(cmd_i.eew);
  assign word_off = opreq_pkg::vaddr_t'(cmd_i.vstart >> shift);

  assign start_addr_o = reg_base + word_off;

  ////////////////////
  // Length and queue command
  ////////////////////

  // A zero vl is acknowledged without walking
  assign empty_o = (cmd_i.vl == '0);

  // Never hand out a zero length
  assign len_o = empty_o ? opreq_pkg::vlen_t'(1) : cmd_i.vl;

  always_comb begin
    opq_cmd_o     = '0;
    opq_cmd_o.eew = cmd_i.eew;
    opq_cmd_o.vl  = len_o;
  end

endmodule

// ==== verilog/opreq_pkg.sv ====
// Single lane, four banks and two operand queues; the sizes below are fixed and not generic
package opreq_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  localparam int unsigned NR_BANKS    = 4;
  localparam int unsigned BANK_IDX_W  = 2;
  localparam int unsigned NR_OPQUEUES = 2;
  localparam int unsigned NR_VINSN    = 4;
  localparam int unsigned NR_MASTERS  = 4;
  localparam int unsigned VREG_WORDS  = 8;
  localparam int unsigned VADDR_W     = 8;
  localparam int unsigned VLEN_W      = 7;
  localparam int unsigned ELEN_W      = 64;

  // Arbiter masters, grouped as two priority classes of two
  localparam int unsigned NR_CLASSES  = 2;
  localparam int unsigned CLASS_SZ    = 2;
  localparam int unsigned CLASS_IDX_W = 1;
  localparam int unsigned MST_IDX_W   = 2;
  localparam int unsigned MST_Q0      = 0;
  localparam int unsigned MST_ALU     = 1;
  localparam int unsigned MST_Q1      = 2;
  localparam int unsigned MST_LDU     = 3;

  ////////////////////
  // Types
  ////////////////////

  typedef logic [1:0]             vid_t;
  typedef logic [VADDR_W-1:0]     vaddr_t;
  typedef logic [VLEN_W-1:0]      vlen_t;
  typedef logic [ELEN_W-1:0]      elen_t;
  typedef logic [ELEN_W/8-1:0]    strb_t;
  typedef logic [VADDR_W-BANK_IDX_W-1:0] bank_addr_t;

  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} vew_e;
  typedef enum logic {OPQ_A, OPQ_B} opqueue_e;

  typedef logic [NR_VINSN-1:0][NR_VINSN-1:0] hazard_tbl_t;

  typedef struct packed {
    vid_t                id;
    logic [4:0]          vs;
    vlen_t               vstart;
    vlen_t               vl;
    vew_e                eew;
    logic [NR_VINSN-1:0] hazard;
  } opreq_cmd_t;

  typedef struct packed {
    vew_e  eew;
    vlen_t vl;
  } opq_cmd_t;

  typedef struct packed {
    bank_addr_t addr;
    logic       wen;
    elen_t      wdata;
    strb_t      be;
    opqueue_e   opqueue;
  } vrf_req_t;

  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } vfu_result_t;

  // Elements carried by one 64-bit word
  function automatic vlen_t elems_per_word(vew_e eew);
    return vlen_t'(8) >> eew;
  endfunction

endpackage
